// File: source/pwmConfig_config.svh
`ifndef PWM_CONFIG_SVH
`define PWM_CONFIG_SVH

// number of PWM output channels
`define PWM_OUTPUTS 4

// width of the visible count and of each compare value
`define PWM_WIDTH 16

// extra prescaler bits below the count for up to 2^31 cycles per step
`define PWM_CLOCK_WIDTH 32

// upper address nibble the device answers to
`define PWM_DEVICE_ID 4'h0

`endif

// File: source/pwmBusPkg.sv
package pwmBusPkg;

	// one bus data word
	typedef logic [31:0] busWord;

	// offset inside the 4 KiB device window
	typedef logic [11:0] localAddr;

	// register map
	localparam localAddr CONFIG_OFFSET = 12'h000;
	localparam localAddr DATA_OFFSET = 12'h004;
	localparam localAddr COMPARE_BASE = 12'h008;
	localparam localAddr COMPARE_STRIDE = 12'h004;

	// compare register of a given channel
	function automatic localAddr compareOffset(input int unsigned channel);
		return localAddr'(COMPARE_BASE + COMPARE_STRIDE * channel);
	endfunction

endpackage

// File: source/pwmTimerPkg.sv
package pwmTimerPkg;

	`include "pwmConfig_config.svh"

	// visible count and compare value
	typedef logic [`PWM_WIDTH-1:0] countWord;

	// prescaler shift amount
	typedef logic [$clog2(`PWM_CLOCK_WIDTH)-1:0] prescaleIdx;

	// highest count bit before the wrap
	typedef logic [$clog2(`PWM_WIDTH)-1:0] topIdx;

	// one bit per channel
	typedef logic [`PWM_OUTPUTS-1:0] channelMask;

	// configuration register with counterEnable in bit 0
	typedef struct packed {
		channelMask outputEnable;
		topIdx topBit;
		prescaleIdx clockScale;
		logic counterEnable;
	} pwmSettings;

	// counter stopped, slow scale, full 16-bit period, outputs off (0x3DC)
	localparam pwmSettings SETTINGS_RESET = '{
		outputEnable: '0,
		topBit: 4'd15,
		clockScale: 5'd14,
		counterEnable: 1'b0
	};

endpackage

// File: source/peripheralBusPort.sv
`include "pwmConfig_config.svh"

module peripheralBusPort (
	input logic peripheralEnable,
	input logic busOe,
	input logic [15:0] busAddress,
	input logic [3:0] deviceId,

	// one hit and one read word per register
	input logic [`PWM_OUTPUTS+1:0] regHit,
	input pwmBusPkg::busWord regData [`PWM_OUTPUTS+2],

	output logic deviceEnable,
	output logic readEnable,
	output pwmBusPkg::localAddr localAddress,
	output pwmBusPkg::busWord busDataRead,
	output logic requestOutput
);

	localparam int regCount = `PWM_OUTPUTS + 2;

	// device window is picked by the upper nibble
	assign deviceEnable = peripheralEnable && (busAddress[15:12] == deviceId);
	assign readEnable = deviceEnable && busOe;
	assign localAddress = busAddress[11:0];

	// at most one register decodes a given offset
	always_comb begin
		busDataRead = '1;
		requestOutput = 1'b0;
		for (int i = 0; i < regCount; i++) begin
			if (regHit[i]) begin
				busDataRead = regData[i];
				requestOutput = 1'b1;
			end
		end
	end

endmodule

// File: source/busRegister.sv
module busRegister #(
	parameter type valueType = pwmBusPkg::busWord,
	parameter pwmBusPkg::localAddr regAddress = '0,
	parameter valueType resetValue = '0,
	parameter bit writable = 1'b1
) (
	input logic clk,
	input logic rstN,
	input logic deviceEnable,
	input logic readEnable,
	input logic busWe,
	input pwmBusPkg::localAddr localAddress,
	input logic [3:0] busByteSelect,
	input pwmBusPkg::busWord busDataWrite,

	// readback source when nothing is stored
	input valueType liveValue,

	output logic regHit,
	output pwmBusPkg::busWord regData,
	output valueType currentValue
);

	import pwmBusPkg::*;

	localparam int valueBits = $bits(valueType);

	logic addrMatch;
	busWord currentWord;

	assign addrMatch = (localAddress == regAddress);

	// zero-extend the value to a bus word
	always_comb begin
		currentWord = '0;
		currentWord[valueBits-1:0] = currentValue;
	end

	assign regHit = readEnable && addrMatch;
	assign regData = currentWord;

	if (writable) begin : genStore
		busWord mergedWord;
		valueType storedValue;

		// replace only the selected byte lanes
		always_comb begin
			for (int b = 0; b < 4; b++) begin
				mergedWord[8*b +: 8] = busByteSelect[b] ? busDataWrite[8*b +: 8]
					: currentWord[8*b +: 8];
			end
		end

		always_ff @(posedge clk) begin
			if (!rstN) begin
				storedValue <= resetValue;
			end else if (deviceEnable && busWe && addrMatch) begin
				storedValue <= valueType'(mergedWord[valueBits-1:0]);
			end
		end

		assign currentValue = storedValue;
	end else begin : genLive
		// read-only so writes are dropped
		assign currentValue = liveValue;
	end

endmodule

// File: source/pwmTimebase.sv
`include "pwmConfig_config.svh"

module pwmTimebase (
	input logic clk,
	input logic rstN,
	input logic counterEnable,
	input pwmTimerPkg::prescaleIdx clockScale,
	input pwmTimerPkg::topIdx topBit,
	output pwmTimerPkg::countWord counterValue
);

	import pwmTimerPkg::*;

	localparam int prescaleBits = `PWM_CLOCK_WIDTH + `PWM_WIDTH;

	logic [prescaleBits-1:0] prescaler;
	logic [prescaleBits-1:0] nextPrescaler;
	logic [prescaleBits-1:0] nextCount;

	// one wider than topIdx so that top 15 gives a shift of 16
	logic [$bits(topIdx):0] topShift;
	logic wrap;

	assign nextPrescaler = prescaler + 1'b1;
	assign nextCount = nextPrescaler >> clockScale;
	assign topShift = topBit + 1'b1;

	// next count would hit 2^(topBit+1)
	assign wrap = |(nextCount >> topShift);

	always_ff @(posedge clk) begin
		if (!rstN || !counterEnable) begin
			prescaler <= '0;
		end else if (wrap) begin
			prescaler <= '0;
		end else begin
			prescaler <= nextPrescaler;
		end
	end

	// each count value lasts 2^clockScale cycles
	assign counterValue = countWord'(prescaler >> clockScale);

endmodule

// File: source/pwmChannel.sv
module pwmChannel (
	input logic clk,
	input logic rstN,
	input logic enable,
	input pwmTimerPkg::countWord counterValue,
	input pwmTimerPkg::countWord compareValue,
	output logic pwmOut
);

	// high while the count is below the compare point
	always_ff @(posedge clk) begin
		if (!rstN) begin
			pwmOut <= 1'b0;
		end else begin
			pwmOut <= enable && (counterValue < compareValue);
		end
	end

endmodule

// File: source/pwmDevice.sv
`include "pwmConfig_config.svh"

module pwmDevice #(
	parameter logic [3:0] deviceId = `PWM_DEVICE_ID
) (
	input logic clk,
	input logic rstN,

	// peripheral bus
	input logic peripheralEnable,
	input logic busWe,
	input logic busOe,
	input logic [15:0] busAddress,
	input logic [3:0] busByteSelect,
	input pwmBusPkg::busWord busDataWrite,
	output pwmBusPkg::busWord busDataRead,
	output logic requestOutput,

	// PWM pins
	output pwmTimerPkg::channelMask pwmEnable,
	output pwmTimerPkg::channelMask pwmOut
);

	import pwmBusPkg::*;
	import pwmTimerPkg::*;

	// slot 0 settings, slot 1 data, then one per compare
	localparam int regCount = `PWM_OUTPUTS + 2;

	logic deviceEnable;
	logic readEnable;
	localAddr localAddress;
	logic [regCount-1:0] regHit;
	busWord regData [regCount];

	pwmSettings settings;
	logic counterEnable;
	prescaleIdx clockScale;
	topIdx topBit;
	channelMask outputEnable;

	busWord dataLive;
	countWord counterValue;
	countWord compareValue [`PWM_OUTPUTS];
	channelMask channelOut;

	peripheralBusPort u_busPort (
		.peripheralEnable(peripheralEnable),
		.busOe(busOe),
		.busAddress(busAddress),
		.deviceId(deviceId),
		.regHit(regHit),
		.regData(regData),
		.deviceEnable(deviceEnable),
		.readEnable(readEnable),
		.localAddress(localAddress),
		.busDataRead(busDataRead),
		.requestOutput(requestOutput)
	);

	busRegister #(
		.valueType(pwmSettings),
		.regAddress(CONFIG_OFFSET),
		.resetValue(SETTINGS_RESET),
		.writable(1'b1)
	) u_settingsReg (
		.clk(clk),
		.rstN(rstN),
		.deviceEnable(deviceEnable),
		.readEnable(readEnable),
		.busWe(busWe),
		.localAddress(localAddress),
		.busByteSelect(busByteSelect),
		.busDataWrite(busDataWrite),
		.liveValue(SETTINGS_RESET),
		.regHit(regHit[0]),
		.regData(regData[0]),
		.currentValue(settings)
	);

	assign counterEnable = settings.counterEnable;
	assign clockScale = settings.clockScale;
	assign topBit = settings.topBit;
	assign outputEnable = settings.outputEnable;

	// count in the low half, channel outputs above it
	always_comb begin
		dataLive = '0;
		dataLive[`PWM_WIDTH-1:0] = counterValue;
		dataLive[`PWM_WIDTH +: `PWM_OUTPUTS] = channelOut;
	end

	// read-only status word of count and outputs
	busRegister #(
		.valueType(busWord),
		.regAddress(DATA_OFFSET),
		.resetValue('0),
		.writable(1'b0)
	) u_dataReg (
		.clk(clk),
		.rstN(rstN),
		.deviceEnable(deviceEnable),
		.readEnable(readEnable),
		.busWe(busWe),
		.localAddress(localAddress),
		.busByteSelect(busByteSelect),
		.busDataWrite(busDataWrite),
		.liveValue(dataLive),
		.regHit(regHit[1]),
		.regData(regData[1]),
		.currentValue()
	);

	pwmTimebase u_timebase (
		.clk(clk),
		.rstN(rstN),
		.counterEnable(counterEnable),
		.clockScale(clockScale),
		.topBit(topBit),
		.counterValue(counterValue)
	);

	for (genvar i = 0; i < `PWM_OUTPUTS; i++) begin : genChannel
		busRegister #(
			.valueType(countWord),
			.regAddress(compareOffset(i)),
			.resetValue('0),
			.writable(1'b1)
		) u_compareReg (
			.clk(clk),
			.rstN(rstN),
			.deviceEnable(deviceEnable),
			.readEnable(readEnable),
			.busWe(busWe),
			.localAddress(localAddress),
			.busByteSelect(busByteSelect),
			.busDataWrite(busDataWrite),
			.liveValue('0),
			.regHit(regHit[i+2]),
			.regData(regData[i+2]),
			.currentValue(compareValue[i])
		);

		pwmChannel u_channel (
			.clk(clk),
			.rstN(rstN),
			.enable(outputEnable[i]),
			.counterValue(counterValue),
			.compareValue(compareValue[i]),
			.pwmOut(channelOut[i])
		);
	end

	assign pwmEnable = outputEnable;
	assign pwmOut = channelOut;

endmodule

// File: tests/pwmDeviceTb.sv
`include "pwmConfig_config.svh"

module pwmDeviceTb;

	import pwmBusPkg::*;
	import pwmTimerPkg::*;

	localparam int clockPeriod = 8;
	localparam int driveDelay = 1;
	localparam int resetCycles = 16;
	localparam logic [3:0] deviceNibble = 4'h0;
	localparam logic [13:0] settingsAtReset = 14'h3DC;
	localparam int randomWrites = 30;
	localparam int compareRounds = 4;
	localparam int stepHoldCycles = 40;
	localparam int slowHoldCycles = 70;
	localparam int compareHoldCycles = 40;
	localparam int disableHoldCycles = 12;

	// upper-bound cycle budget of each phase
	localparam int resetPhaseCycles = resetCycles + 4;
	localparam int resetReadCycles = 8;
	localparam int laneWriteCycles = 2 * randomWrites + 8;
	localparam int decodeCycles = 20;
	localparam int stepCycles = stepHoldCycles + slowHoldCycles + 8;
	localparam int compareCycles = compareRounds * (compareHoldCycles + 8) + 4;
	localparam int disableCycles = disableHoldCycles + 8;
	localparam int totalCycles = resetPhaseCycles + resetReadCycles + laneWriteCycles
		+ decodeCycles + stepCycles + compareCycles + disableCycles;
	localparam int watchdogCycles = totalCycles + totalCycles / 5;

	logic clk;
	logic rstN;
	logic peripheralEnable;
	logic busWe;
	logic busOe;
	logic [15:0] busAddress;
	logic [3:0] busByteSelect;
	busWord busDataWrite;
	busWord busDataRead;
	logic requestOutput;
	channelMask pwmEnable;
	channelMask pwmOut;

	// reference model state
	logic [13:0] modelSettings;
	logic [15:0] modelCompare [`PWM_OUTPUTS];
	logic [15:0] modelCount;
	longint unsigned modelStep;
	logic [`PWM_OUTPUTS-1:0] modelOut;
	busWord expectedRead;
	logic expectedRequest;
	logic readingData;

	logic countStepActive = 1'b0;
	logic decodeCaseActive = 1'b0;
	int mismatchCount = 0;
	int decodeErrorCount = 0;

	pwmDevice u_dut (
		.clk(clk),
		.rstN(rstN),
		.peripheralEnable(peripheralEnable),
		.busWe(busWe),
		.busOe(busOe),
		.busAddress(busAddress),
		.busByteSelect(busByteSelect),
		.busDataWrite(busDataWrite),
		.busDataRead(busDataRead),
		.requestOutput(requestOutput),
		.pwmEnable(pwmEnable),
		.pwmOut(pwmOut)
	);

	initial begin
		clk = 1'b0;
		forever #(clockPeriod / 2) clk = ~clk;
	end

	function automatic busWord mergeLanes(input busWord oldWord, input busWord newWord,
		input logic [3:0] lanes);
		busWord merged;
		merged = oldWord;
		for (int b = 0; b < 4; b++) begin
			if (lanes[b]) begin
				merged[8*b +: 8] = newWord[8*b +: 8];
			end
		end
		return merged;
	endfunction

	// enable in bit 0, then scale, top and channel enables
	function automatic busWord settingsWord(input logic run, input logic [4:0] scale,
		input logic [3:0] top, input logic [3:0] outputs);
		return {18'd0, outputs, top, scale, run};
	endfunction

	function automatic logic [11:0] compareAddress(input int channel);
		return 12'h008 + 12'(4 * channel);
	endfunction

	function automatic logic [15:0] wrapMask(input logic [3:0] top);
		int unsigned full;
		full = (32'd1 << (int'(top) + 1)) - 1;
		return full[15:0];
	endfunction

	// registers take a write on the same edge as the device
	always @(posedge clk) begin
		if (!rstN) begin
			modelSettings <= settingsAtReset;
			for (int i = 0; i < `PWM_OUTPUTS; i++) begin
				modelCompare[i] <= '0;
			end
		end else if (peripheralEnable && busWe && busAddress[15:12] == deviceNibble) begin
			if (busAddress[11:0] == 12'h000) begin
				modelSettings <= 14'(mergeLanes({18'd0, modelSettings}, busDataWrite,
					busByteSelect));
			end
			for (int i = 0; i < `PWM_OUTPUTS; i++) begin
				if (busAddress[11:0] == compareAddress(i)) begin
					modelCompare[i] <= 16'(mergeLanes({16'd0, modelCompare[i]}, busDataWrite,
						busByteSelect));
				end
			end
		end
	end

	// count steps every 2^scale cycles and wraps after 2^(top+1)-1
	always @(posedge clk) begin
		if (!rstN || !modelSettings[0]) begin
			modelStep <= 0;
			modelCount <= '0;
		end else if (modelStep + 1 == (64'd1 << modelSettings[5:1])) begin
			modelStep <= 0;
			modelCount <= (modelCount + 16'd1) & wrapMask(modelSettings[9:6]);
		end else begin
			modelStep <= modelStep + 1;
		end
	end

	always @(posedge clk) begin
		for (int i = 0; i < `PWM_OUTPUTS; i++) begin
			if (!rstN) begin
				modelOut[i] <= 1'b0;
			end else begin
				modelOut[i] <= modelSettings[10+i] && (modelCount < modelCompare[i]);
			end
		end
	end

	// what a read should return this cycle
	always_comb begin
		expectedRead = '1;
		expectedRequest = 1'b0;
		if (peripheralEnable && busOe && busAddress[15:12] == deviceNibble) begin
			if (busAddress[11:0] == 12'h000) begin
				expectedRead = {18'd0, modelSettings};
				expectedRequest = 1'b1;
			end
			if (busAddress[11:0] == 12'h004) begin
				expectedRead = {12'd0, modelOut, modelCount};
				expectedRequest = 1'b1;
			end
			for (int i = 0; i < `PWM_OUTPUTS; i++) begin
				if (busAddress[11:0] == compareAddress(i)) begin
					expectedRead = {16'd0, modelCompare[i]};
					expectedRequest = 1'b1;
				end
			end
		end
	end

	assign readingData = peripheralEnable && busOe && busAddress == {deviceNibble, 12'h004};

	readCheck: assert property (@(posedge clk) disable iff (!rstN)
		busDataRead == expectedRead)
	else begin
		mismatchCount++;
		$display("Mismatch at %0t: busDataRead expected %h, actual %h", $time,
			$sampled(expectedRead), $sampled(busDataRead));
	end

	requestCheck: assert property (@(posedge clk) disable iff (!rstN)
		requestOutput == expectedRequest)
	else begin
		mismatchCount++;
		$display("Mismatch at %0t: requestOutput expected %b, actual %b", $time,
			$sampled(expectedRequest), $sampled(requestOutput));
	end

	outputCheck: assert property (@(posedge clk) disable iff (!rstN)
		pwmOut == modelOut)
	else begin
		mismatchCount++;
		$display("Mismatch at %0t: pwmOut expected %b, actual %b", $time,
			$sampled(modelOut), $sampled(pwmOut));
	end

	enableCheck: assert property (@(posedge clk) disable iff (!rstN)
		pwmEnable == modelSettings[13:10])
	else begin
		mismatchCount++;
		$display("Mismatch at %0t: pwmEnable expected %b, actual %b", $time,
			$sampled(modelSettings[13:10]), $sampled(pwmEnable));
	end

	// with scale 0 and top 3 the count steps by one modulo 16
	countStep: assert property (@(posedge clk) disable iff (!rstN)
		countStepActive && $past(countStepActive) |->
			busDataRead[15:0] == (($past(busDataRead[15:0]) + 16'd1) & 16'h000F))
	else begin
		mismatchCount++;
		$display("Mismatch at %0t: count expected %h, actual %h", $time,
			($past(busDataRead[15:0]) + 16'd1) & 16'h000F, $sampled(busDataRead[15:0]));
	end

	statusOutputs: assert property (@(posedge clk) disable iff (!rstN)
		readingData |-> busDataRead[19:16] == pwmOut)
	else begin
		mismatchCount++;
		$display("Mismatch at %0t: data bits 19..16 expected %b, actual %b", $time,
			$sampled(pwmOut), $sampled(busDataRead[19:16]));
	end

	ignoredAccess: assert property (@(posedge clk) disable iff (!rstN)
		decodeCaseActive |-> !requestOutput && busDataRead == '1)
	else begin
		decodeErrorCount++;
		$display("Mismatch at %0t: ignored access requestOutput expected 0, actual %b;",
			$time, $sampled(requestOutput),
			" busDataRead expected %h, actual %h", 32'hFFFF_FFFF, $sampled(busDataRead));
	end

	task automatic busIdle();
		peripheralEnable = 1'b0;
		busWe = 1'b0;
		busOe = 1'b0;
		busAddress = '0;
		busByteSelect = '0;
		busDataWrite = '0;
	endtask

	// one bus cycle entered just after a rising edge
	task automatic busCycle(input logic enable, input logic writeStrobe,
		input logic readStrobe, input logic [15:0] address, input busWord data,
		input logic [3:0] lanes);
		peripheralEnable = enable;
		busWe = writeStrobe;
		busOe = readStrobe;
		busAddress = address;
		busDataWrite = data;
		busByteSelect = lanes;
		@(posedge clk);
		#driveDelay;
		busIdle();
	endtask

	task automatic busWrite(input logic [11:0] offset, input busWord data,
		input logic [3:0] lanes);
		busCycle(1'b1, 1'b1, 1'b0, {deviceNibble, offset}, data, lanes);
	endtask

	task automatic busRead(input logic [11:0] offset);
		busCycle(1'b1, 1'b0, 1'b1, {deviceNibble, offset}, '0, 4'h0);
	endtask

	task automatic readAll();
		busRead(12'h000);
		busRead(12'h004);
		for (int i = 0; i < `PWM_OUTPUTS; i++) begin
			busRead(compareAddress(i));
		end
	endtask

	// keep busOe on the data register for a number of cycles
	task automatic watchData(input int cycles, input logic stepping);
		peripheralEnable = 1'b1;
		busOe = 1'b1;
		busAddress = {deviceNibble, 12'h004};
		countStepActive = stepping;
		repeat (cycles) @(posedge clk);
		#driveDelay;
		countStepActive = 1'b0;
		busIdle();
	endtask

	task automatic randomLaneWrites();
		int target;
		busWord data;
		logic [11:0] offset;
		for (int n = 0; n < randomWrites; n++) begin
			target = $urandom_range(0, `PWM_OUTPUTS);
			data = $urandom;
			if (target == 0) begin
				offset = 12'h000;
				// counter stays stopped here
				data[0] = 1'b0;
			end else begin
				offset = compareAddress(target - 1);
			end
			busWrite(offset, data, 4'($urandom_range(0, 15)));
			busRead(offset);
		end
	endtask

	task automatic decodeCases();
		decodeCaseActive = 1'b1;
		// wrong device nibble
		busCycle(1'b1, 1'b1, 1'b1, 16'h1000, $urandom, 4'hF);
		busCycle(1'b0, 1'b1, 1'b1, 16'h0008, $urandom, 4'hF);
		// read strobe low
		busCycle(1'b1, 1'b0, 1'b0, 16'h0000, $urandom, 4'hF);
		// unmapped offsets
		busCycle(1'b1, 1'b1, 1'b1, 16'h0020, $urandom, 4'hF);
		busCycle(1'b1, 1'b1, 1'b1, 16'h0002, $urandom, 4'hF);
		// data register is read-only
		busCycle(1'b1, 1'b1, 1'b0, 16'h0004, $urandom, 4'hF);
		decodeCaseActive = 1'b0;
		readAll();
	endtask

	task automatic countStepping();
		busWrite(12'h000, settingsWord(1'b1, 5'd0, 4'd3, 4'd0), 4'hF);
		watchData(stepHoldCycles, 1'b1);
		// stop first so scale 2 starts from a cleared prescaler
		busWrite(12'h000, settingsWord(1'b0, 5'd2, 4'd3, 4'd0), 4'hF);
		busWrite(12'h000, settingsWord(1'b1, 5'd2, 4'd3, 4'd0), 4'hF);
		watchData(slowHoldCycles, 1'b0);
	endtask

	task automatic compareRuns();
		logic [3:0] outputs;
		busWrite(12'h000, settingsWord(1'b0, 5'd0, 4'd3, 4'd0), 4'hF);
		for (int r = 0; r < compareRounds; r++) begin
			// 16 and 17 keep an output high all period
			for (int i = 0; i < `PWM_OUTPUTS; i++) begin
				busWrite(compareAddress(i), busWord'($urandom_range(0, 17)), 4'hF);
			end
			outputs = 4'($urandom_range(0, 15));
			busWrite(12'h000, settingsWord(1'b1, 5'd0, 4'd3, outputs), 4'hF);
			watchData(compareHoldCycles, 1'b0);
		end
	endtask

	task automatic disableCounter();
		busWrite(12'h000, settingsWord(1'b0, 5'd0, 4'd3, 4'hF), 4'hF);
		watchData(disableHoldCycles, 1'b0);
	endtask

	initial begin
		void'($urandom(32'h00f4_721f));
		rstN = 1'b0;
		busIdle();
		repeat (resetCycles) @(posedge clk);
		#driveDelay;
		rstN = 1'b1;

		readAll();
		randomLaneWrites();
		readAll();
		decodeCases();
		countStepping();
		compareRuns();
		disableCounter();
		repeat (2) @(posedge clk);
		#driveDelay;

		$display("Errors: %0d mismatches, %0d decode failures", mismatchCount,
			decodeErrorCount);
		if (mismatchCount + decodeErrorCount == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		#(watchdogCycles * clockPeriod);
		$display("Watchdog timeout: the run did not finish within %0d cycles", watchdogCycles);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: compile.f
+incdir+source
source/pwmBusPkg.sv
source/pwmTimerPkg.sv
source/peripheralBusPort.sv
source/busRegister.sv
source/pwmTimebase.sv
source/pwmChannel.sv
source/pwmDevice.sv
tests/pwmDeviceTb.sv
